//--- common/uword_pkg.sv
// microword layout for the sequencer
// widths, opcode values and the jump / dispatch views of one word
`default_nettype none

package uword_pkg;

   localparam int uword_w = 32;
   localparam int upc_w   = 8;

   typedef enum logic [1:0]
   {
      op_alu  = 2'd0,
      op_jump = 2'd1,
      op_disp = 2'd2
   } op_t;

   // op and popj sit at the same bits in both views, so the op field
   // alone tells which view is live
   typedef union packed
   {
      struct packed
      {
         op_t              op;
         logic             popj;
         logic             invert;    // jump when jcond is low
         logic             next_n;
         logic             call;
         logic             ret;       // call and ret together is a microcode write
         logic             nop_hint;
         logic [15:0]      spare;
         logic [upc_w-1:0] target;
      } jump_f;
      struct packed
      {
         op_t              op;
         logic             popj;
         logic             disp_n;
         logic             push;
         logic             ret;
         logic [17:0]      spare;
         logic [upc_w-1:0] base;
      } disp_f;
   } uword_u;

endpackage

`default_nettype wire

//--- common/useq_pkg.sv
// sequencer phase codes, next-pc source codes and storage depths
`default_nettype none

package useq_pkg;

   typedef enum logic [1:0]
   {
      ph_fetch = 2'd0,
      ph_alu   = 2'd1,
      ph_write = 2'd2
   } phase_t;

   // same order as the classic four-way pc select
   typedef enum logic [1:0]
   {
      pcs_spc = 2'd0,
      pcs_ir  = 2'd1,
      pcs_dpc = 2'd2,
      pcs_ipc = 2'd3
   } pcs_t;

   localparam int store_depth = 256;
   localparam int stack_depth = 16;
   localparam int sp_w        = 4;

endpackage

`default_nettype wire

//--- hdl/useq_phase.sv
// three-phase cycle generator for the microcode sequencer
`timescale 1ns/100ps
`default_nettype none

module useq_phase
   import useq_pkg::*;
(
   input  wire    clk,
   input  wire    reset,
   input  wire    run,
   input  wire    uinst_ready,
   output phase_t phase,
   output logic   uinst_valid
);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase <= ph_fetch;
      end
      else
      begin
         case (phase)
            ph_fetch:
            begin
               if (run)
                  phase <= ph_alu;
            end
            ph_alu:
            begin
               phase <= ph_write;
            end
            ph_write:
            begin
               // stay here until the datapath takes the instruction
               if (uinst_ready)
                  phase <= ph_fetch;
            end
            default:
            begin
               phase <= ph_fetch;
            end
         endcase
      end
   end

   assign uinst_valid = (phase == ph_write);

   a_phase_legal: assert property (@(posedge clk) disable iff (reset)
      phase inside {ph_fetch, ph_alu, ph_write});

endmodule

`default_nettype wire

//--- control/useq_control.sv
// branch, return stack and no-op decisions of the sequencer
// decodes the current word as a jump or a dispatch
`timescale 1ns/100ps
`default_nettype none

module useq_control
   import uword_pkg::*, useq_pkg::*;
(
   input  wire    clk,
   input  wire    reset,
   input  phase_t phase,
   input  uword_u uword,
   input  wire    jcond,
   input  wire    trap,
   input  wire    transfer,
   output logic   push,
   output logic   pop,
   output pcs_t   pcs,
   output logic   nop,
   output logic   ucode_write
);

   logic inop;
   logic iwrited;
   logic nop_seq;
   logic is_jump;
   logic is_disp;
   logic taken;
   logic jplain;
   logic jcall;
   logic jret;
   logic iwrite;
   logic dpush;
   logic dret;
   logic ignpopj;
   logic popj;
   logic n;

   ////////////////////////////////////////////////////////////////////////////
   // word decode

   // a no-op word is not decoded at all
   assign nop_seq = inop | iwrited;

   assign is_jump = (uword.jump_f.op == op_jump) & ~nop_seq;
   assign is_disp = (uword.disp_f.op == op_disp) & ~nop_seq;

   // inverted sense means the jump goes when jcond is low
   assign taken = jcond ^ uword.jump_f.invert;

   assign jplain = is_jump & ~uword.jump_f.call & ~uword.jump_f.ret;
   assign jcall  = is_jump & uword.jump_f.call & ~uword.jump_f.ret;
   assign jret   = is_jump & ~uword.jump_f.call & uword.jump_f.ret;
   assign iwrite = is_jump & uword.jump_f.call & uword.jump_f.ret;

   // push and ret together is the fall-through form and moves neither way
   assign dpush = is_disp & uword.disp_f.push & ~uword.disp_f.ret;
   assign dret  = is_disp & ~uword.disp_f.push & uword.disp_f.ret;

   // a dispatch without its return bit ignores popj
   assign ignpopj = is_disp & ~uword.disp_f.ret;

   // the word after a microcode write always returns
   assign popj = ((uword.jump_f.popj & ~nop_seq) | iwrited) & ~ignpopj;

   ////////////////////////////////////////////////////////////////////////////
   // stack and pc source

   assign pop  = popj | dret | (jret & taken);
   assign push = (jcall & taken) | dpush;

   always_comb
   begin
      if (pop)
         pcs = pcs_spc;
      else if ((jplain | jcall) & taken)
         pcs = pcs_ir;
      else if (is_disp)
         pcs = pcs_dpc;
      else
         pcs = pcs_ipc;
   end

   ////////////////////////////////////////////////////////////////////////////
   // no-op flag for the following instruction

   assign n = trap | iwrited | (is_disp & uword.disp_f.disp_n) |
              ((jplain | jcall | jret) & taken & uword.jump_f.next_n);

   // nop_hint marks a pure branch with no datapath work
   assign nop         = nop_seq | (is_jump & uword.jump_f.nop_hint);
   assign ucode_write = iwrited & transfer;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         inop    <= 1'b0;
         iwrited <= 1'b0;
      end
      else if (transfer)
      begin
         inop    <= n;
         iwrited <= iwrite;
      end
   end

   // decisions only count in the write phase, where the top level transfers
   a_transfer_in_write: assert property (@(posedge clk) disable iff (reset)
      transfer |-> phase == ph_write);

   // microcode must not combine a taken call or dispatch push with a return
   a_push_pop_excl: assert property (@(posedge clk) disable iff (reset)
      transfer |-> !(push && pop));

endmodule

`default_nettype wire

//--- control/spc_stack.sv
// subroutine return stack of the sequencer
// a push stores the address after the caller, a pop exposes the entry below
`timescale 1ns/100ps
`default_nettype none

module spc_stack
   import uword_pkg::*, useq_pkg::*;
(
   input  wire              clk,
   input  wire              reset,
   input  wire              push,
   input  wire              pop,
   input  wire              transfer,
   input  wire [upc_w-1:0]  push_addr,
   output logic [upc_w-1:0] top_addr,
   output logic [sp_w-1:0]  sp
);

   logic [upc_w-1:0] stack_mem [stack_depth];
   logic [sp_w-1:0]  sp_up;
   logic [sp_w-1:0]  sp_down;

   // occupancy is one bit wider than sp so that full and empty differ
   logic [sp_w:0]    level;

   assign sp_up   = sp + {{(sp_w-1){1'b0}}, 1'b1};
   assign sp_down = sp - {{(sp_w-1){1'b0}}, 1'b1};

   // sp points at the current top entry
   assign top_addr = stack_mem[sp];

   always_ff @(posedge clk)
   begin
      if (transfer && push)
         stack_mem[sp_up] <= push_addr + {{(upc_w-1){1'b0}}, 1'b1};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sp    <= '0;
         level <= '0;
      end
      else if (transfer)
      begin
         if (push)
         begin
            sp    <= sp_up;
            level <= level + {{sp_w{1'b0}}, 1'b1};
         end
         else if (pop)
         begin
            sp    <= sp_down;
            level <= level - {{sp_w{1'b0}}, 1'b1};
         end
      end
   end

   a_no_underflow: assert property (@(posedge clk) disable iff (reset)
      transfer && pop |-> level != '0);

   // an overflow wraps the pointer and loses the oldest return address
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      transfer && push |-> level != (sp_w+1)'(stack_depth));

endmodule

`default_nettype wire

//--- hdl/control_store.sv
// writable microcode memory
// external load port first, then the microcode-write port
`timescale 1ns/100ps
`default_nettype none

module control_store
   import uword_pkg::*;
(
   input  wire               clk,
   input  wire               load_valid,
   input  wire [upc_w-1:0]   load_addr,
   input  wire [uword_w-1:0] load_data,
   input  wire               ucode_write,
   input  wire [upc_w-1:0]   write_addr,
   input  wire [uword_w-1:0] write_data,
   input  wire [upc_w-1:0]   read_addr,
   output uword_u            uword
);

   logic [uword_w-1:0] store [2**upc_w];

   always_ff @(posedge clk)
   begin
      if (load_valid)
         store[load_addr] <= load_data;
      else if (ucode_write)
         store[write_addr] <= write_data;
   end

   // the word for a new upc is ready one cycle after upc changes
   // and holds for as long as upc holds
   always_ff @(posedge clk)
   begin
      uword <= store[read_addr];
   end

endmodule

`default_nettype wire

//--- hdl/next_upc.sv
// micro program counter and its four-way next-address select
`timescale 1ns/100ps
`default_nettype none

module next_upc
   import useq_pkg::*;
(
   input  wire                              clk,
   input  wire                              reset,
   input  wire                              transfer,
   input  pcs_t                             pcs,
   input  wire [$clog2(store_depth)-1:0]    jump_target,
   input  wire [$clog2(store_depth)-1:0]    disp_base,
   input  wire [1:0]                        disp_key,
   input  wire [$clog2(store_depth)-1:0]    top_addr,
   output logic [$clog2(store_depth)-1:0]   upc
);

   logic [$clog2(store_depth)-1:0] upc_next;

   always_comb
   begin
      case (pcs)
         pcs_spc:
            upc_next = top_addr;
         pcs_ir:
            upc_next = jump_target;
         pcs_dpc:
            upc_next = disp_base + {{($clog2(store_depth)-2){1'b0}}, disp_key};
         // pcs_ipc, plain step to the next word
         default:
            upc_next = upc + {{($clog2(store_depth)-1){1'b0}}, 1'b1};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         upc <= '0;
      else if (transfer)
         upc <= upc_next;
   end

endmodule

`default_nettype wire

//--- hdl/useq_top.sv
// top level of the microcode sequencer
// phase generator, control, return stack, control store and upc
`timescale 1ns/100ps
`default_nettype none

module useq_top
   import uword_pkg::*, useq_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire                load_valid,
   input  wire [upc_w-1:0]    load_addr,
   input  wire [uword_w-1:0]  load_data,
   input  wire                run,
   input  wire                jcond,
   input  wire [1:0]          disp_key,
   input  wire                trap,
   output logic               uinst_valid,
   input  wire                uinst_ready,
   output logic [uword_w-1:0] uinst,
   output logic [upc_w-1:0]   upc,
   output logic               uinst_nop
);

   phase_t           phase;
   uword_u           uword;
   pcs_t             pcs;
   logic             transfer;
   logic             push;
   logic             pop;
   logic             ucode_write;
   logic [upc_w-1:0] top_addr;

   assign transfer = uinst_valid & uinst_ready;
   assign uinst    = uword;

   ////////////////////////////////////////////////////////////////////////////
   // sequencing

   useq_phase u_phase
   (
      .clk         (clk),
      .reset       (reset),
      .run         (run),
      .uinst_ready (uinst_ready),
      .phase       (phase),
      .uinst_valid (uinst_valid)
   );

   useq_control u_control
   (
      .clk         (clk),
      .reset       (reset),
      .phase       (phase),
      .uword       (uword),
      .jcond       (jcond),
      .trap        (trap),
      .transfer    (transfer),
      .push        (push),
      .pop         (pop),
      .pcs         (pcs),
      .nop         (uinst_nop),
      .ucode_write (ucode_write)
   );

   spc_stack u_stack
   (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .pop       (pop),
      .transfer  (transfer),
      .push_addr (upc),
      .top_addr  (top_addr),
      .sp        ()
   );

   ////////////////////////////////////////////////////////////////////////////
   // microcode and addressing

   // a microcode write stores the word that follows the write instruction
   control_store u_store
   (
      .clk         (clk),
      .load_valid  (load_valid),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .ucode_write (ucode_write),
      .write_addr  (top_addr),
      .write_data  (uinst),
      .read_addr   (upc),
      .uword       (uword)
   );

   next_upc u_next_upc
   (
      .clk         (clk),
      .reset       (reset),
      .transfer    (transfer),
      .pcs         (pcs),
      .jump_target (uword.jump_f.target),
      .disp_base   (uword.disp_f.base),
      .disp_key    (disp_key),
      .top_addr    (top_addr),
      .upc         (upc)
   );

endmodule

`default_nettype wire

//--- dv/useq_tb.sv
// testbench for the microcode sequencer
// microprogram load, LFSR stimulus, reference pc model and checking assertions
`timescale 1ns/100ps
`default_nettype none

module useq_tb;

   logic        clk;
   logic        reset;
   logic        load_valid;
   logic [7:0]  load_addr;
   logic [31:0] load_data;
   logic        run;
   logic        jcond;
   logic [1:0]  disp_key;
   logic        trap;
   logic        uinst_valid;
   logic        uinst_ready;
   logic [31:0] uinst;
   logic [7:0]  upc;
   logic        uinst_nop;

   // reference model state
   logic [31:0] m_mem [256];
   logic [7:0]  m_stk [16];
   logic [3:0]  m_sp;
   logic [7:0]  m_upc;
   logic        m_inop;
   logic        m_iwrited;
   logic [15:0] lfsr;
   int          xfer_count;
   int          n_push;
   int          n_pop;
   int          n_write;
   int          n_nop;

   wire        xfer = uinst_valid & uinst_ready;
   wire [31:0] exp_word = m_mem[m_upc];
   wire        exp_nop = m_inop | m_iwrited |
                         (exp_word[31:30] == 2'd1 && exp_word[24] && !m_inop && !m_iwrited);

   useq_top u_useq_top
   (
      .clk         (clk),
      .reset       (reset),
      .load_valid  (load_valid),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .run         (run),
      .jcond       (jcond),
      .disp_key    (disp_key),
      .trap        (trap),
      .uinst_valid (uinst_valid),
      .uinst_ready (uinst_ready),
      .uinst       (uinst),
      .upc         (upc),
      .uinst_nop   (uinst_nop)
   );

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      stop_with_error($sformatf("Error %s: got %h, expected %h", name, got, exp));
   endtask

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
   endfunction

   task automatic take_bit(output logic b);
      lfsr = lfsr_step(lfsr);
      b = lfsr[0];
   endtask

   function automatic logic [31:0] alu_word(input logic popj, input logic [15:0] tag);
      return {2'b00, popj, 13'd0, tag};
   endfunction

   function automatic logic [31:0] jump_word(input logic invert, input logic next_n,
      input logic call, input logic ret, input logic popj, input logic hint,
      input logic [7:0] target);
      return {2'b01, popj, invert, next_n, call, ret, hint, 16'd0, target};
   endfunction

   function automatic logic [31:0] disp_word(input logic popj, input logic disp_n,
      input logic push, input logic ret, input logic [7:0] base);
      return {2'b10, popj, disp_n, push, ret, 18'd0, base};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // reference pc model, stepped on each transfer

   always @(posedge clk)
   begin
      logic [31:0] w;
      logic        seq;
      logic        taken;
      logic        push;
      logic        pop;
      logic        n;
      logic        iw;
      logic [7:0]  nxt;
      logic [7:0]  top;
      if (reset)
      begin
         m_upc     = 8'd0;
         m_sp      = 4'd0;
         m_inop    = 1'b0;
         m_iwrited = 1'b0;
      end
      else if (xfer)
      begin
         w     = m_mem[m_upc];
         seq   = m_inop | m_iwrited;
         taken = jcond ^ w[28];
         top   = m_stk[m_sp];
         push  = 1'b0;
         pop   = 1'b0;
         iw    = 1'b0;
         n     = trap;
         nxt   = m_upc + 8'd1;
         if (seq)
         begin
            // a no-op word is not decoded; after a microcode write it returns
            pop = m_iwrited;
            n   = trap | m_iwrited;
         end
         else if (w[31:30] == 2'd1)
         begin
            if (w[26] && w[25])
            begin
               iw  = 1'b1;
               pop = w[29];
            end
            else if (w[25])
               pop = w[29] | taken;
            else
            begin
               pop  = w[29];
               push = w[26] & taken;
               if (taken)
                  nxt = w[7:0];
            end
            if (!(w[26] && w[25]) && taken && w[27])
               n = 1'b1;
         end
         else if (w[31:30] == 2'd2)
         begin
            push = w[27] & ~w[26];
            pop  = (w[29] & w[26]) | (~w[27] & w[26]);
            n    = trap | w[28];
            nxt  = w[7:0] + {6'd0, disp_key};
         end
         else
            pop = w[29];
         if (pop)
            nxt = top;
         if (m_iwrited)
         begin
            m_mem[top] = w;
            n_write++;
         end
         if (push)
         begin
            m_sp        = m_sp + 4'd1;
            m_stk[m_sp] = m_upc + 8'd1;
            n_push++;
         end
         else if (pop)
         begin
            m_sp = m_sp - 4'd1;
            n_pop++;
         end
         if (seq)
            n_nop++;
         m_upc     = nxt;
         m_inop    = n;
         m_iwrited = iw;
         xfer_count++;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks

   a_upc: assert property (@(posedge clk) disable iff (reset) xfer |-> upc == m_upc)
      else report_value("upc", {24'd0, $sampled(upc)}, {24'd0, $sampled(m_upc)});

   a_nop: assert property (@(posedge clk) disable iff (reset) xfer |-> uinst_nop == exp_nop)
      else report_value("uinst_nop", {31'd0, $sampled(uinst_nop)}, {31'd0, $sampled(exp_nop)});

   a_word: assert property (@(posedge clk) disable iff (reset) xfer |-> uinst == exp_word)
      else report_value("uinst", $sampled(uinst), $sampled(exp_word));

   // the offered instruction holds while the datapath stalls
   a_stall: assert property (@(posedge clk) disable iff (reset)
      uinst_valid && !uinst_ready |=> $stable(uinst) && $stable(upc))
      else stop_with_error("uinst or upc changed while the transfer was stalled");

   // nothing is offered before the sequencer is started
   a_idle: assert property (@(posedge clk) disable iff (reset) !run |-> !uinst_valid)
      else stop_with_error("uinst_valid was high before run was raised");

   // after a transfer come fetch and alu, then the next offer
   a_phases: assert property (@(posedge clk) disable iff (reset)
      xfer |=> !uinst_valid ##1 !uinst_valid ##1 uinst_valid)
      else stop_with_error("uinst_valid did not follow the fetch, alu and write phases");

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   task automatic drive_random;
      logic b0;
      logic b1;
      take_bit(b0);
      jcond = b0;
      take_bit(b0);
      take_bit(b1);
      disp_key = {b1, b0};
      take_bit(b0);
      take_bit(b1);
      uinst_ready = b0 | b1;
      // a trap on word 13 turns the popj word at 14 into a no-op
      trap = (upc == 8'h13);
   endtask

   task automatic wait_transfer;
      int start;
      int cycles;
      start  = xfer_count;
      cycles = 0;
      while (xfer_count == start)
      begin
         @(negedge clk);
         drive_random();
         cycles++;
         if (cycles > 40)
            stop_with_error("timeout waiting for an instruction transfer");
      end
   endtask

   task automatic build_program(output logic [31:0] p [256]);
      for (int a = 0; a < 256; a++)
         p[a] = alu_word(1'b0, {a[7:0], ~a[7:0]});
      p[8'h04] = jump_word(0, 0, 0, 0, 0, 0, 8'h08);
      p[8'h08] = jump_word(1, 0, 0, 0, 0, 0, 8'h0a);
      p[8'h0a] = jump_word(0, 0, 1, 0, 0, 0, 8'h40);
      p[8'h0b] = disp_word(0, 0, 1, 0, 8'h50);
      p[8'h0c] = disp_word(0, 0, 1, 0, 8'h58);
      p[8'h0d] = jump_word(0, 1, 0, 0, 0, 0, 8'h0f);
      p[8'h0e] = disp_word(0, 1, 0, 0, 8'h0f);
      p[8'h0f] = alu_word(1'b1, 16'h000f);
      p[8'h14] = alu_word(1'b1, 16'h0014);
      p[8'h15] = jump_word(0, 0, 1, 0, 0, 0, 8'h60);
      p[8'h17] = jump_word(1, 0, 1, 0, 0, 0, 8'h40);
      p[8'h18] = disp_word(0, 0, 0, 0, 8'h00);
      // nested subroutines with conditional returns
      p[8'h41] = jump_word(0, 0, 1, 0, 0, 0, 8'h48);
      p[8'h42] = jump_word(0, 0, 0, 1, 0, 0, 8'h00);
      p[8'h43] = alu_word(1'b1, 16'h0043);
      p[8'h48] = jump_word(0, 0, 0, 0, 0, 1, 8'h49);
      p[8'h49] = jump_word(1, 0, 0, 1, 0, 0, 8'h00);
      p[8'h4a] = alu_word(1'b1, 16'h004a);
      for (int a = 8'h50; a < 8'h54; a++)
         p[a] = alu_word(1'b1, 16'h0050);
      p[8'h58] = disp_word(0, 0, 0, 1, 8'h00);
      p[8'h59] = disp_word(0, 0, 0, 1, 8'h00);
      p[8'h5a] = disp_word(0, 0, 1, 1, 8'h5c);
      p[8'h5b] = disp_word(0, 0, 0, 1, 8'h00);
      for (int a = 8'h5c; a < 8'h60; a++)
         p[a] = alu_word(1'b1, 16'h005c);
      // microcode write of the word at 62 over the return address
      p[8'h61] = jump_word(0, 0, 1, 1, 0, 0, 8'h00);
      p[8'h62] = alu_word(1'b0, 16'hbeef);
   endtask

   initial
   begin
      logic [31:0] prog [256];
      clk         = 1'b0;
      reset       = 1'b1;
      load_valid  = 1'b0;
      load_addr   = 8'd0;
      load_data   = 32'd0;
      run         = 1'b0;
      jcond       = 1'b0;
      disp_key    = 2'd0;
      trap        = 1'b0;
      uinst_ready = 1'b0;
      lfsr        = 16'd69;
      xfer_count  = 0;
      n_push      = 0;
      n_pop       = 0;
      n_write     = 0;
      n_nop       = 0;
      build_program(prog);
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int a = 0; a < 256; a++)
      begin
         load_valid = 1'b1;
         load_addr  = a[7:0];
         load_data  = prog[a];
         m_mem[a]   = prog[a];
         @(negedge clk);
      end
      load_valid = 1'b0;
      run        = 1'b1;
      for (int i = 0; i < 600; i++)
         wait_transfer();
      if (n_push > 0 && n_pop > 0 && n_write > 0 && n_nop > 0)
      begin
         $display("Done: no errors");
         $finish;
      end
      else
         stop_with_error("the microprogram did not reach every stack and no-op case");
   end

endmodule

`default_nettype wire

//--- project.f
common/uword_pkg.sv
common/useq_pkg.sv
hdl/useq_phase.sv
control/useq_control.sv
control/spc_stack.sv
hdl/control_store.sv
hdl/next_upc.sv
hdl/useq_top.sv
dv/useq_tb.sv

//--- Makefile
# Verilator build and run of the sequencer testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --assert --timing --top-module useq_tb -f project.f -Mdir obj_dir
	./obj_dir/Vuseq_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
